/* spi_pkg.sv */
// Shared widths, types, register map and engine states for the SPI mode 3 master subsystem
package spi_pkg;

  // frame and chip-select geometry
  localparam int frame_bits   = 32;
  localparam int cs_count     = 4;
  localparam int cs_sel_bits  = $clog2(cs_count);
  localparam int bit_cnt_bits = $clog2(frame_bits);

  // serial clock half-period is div + 1 system clocks
  localparam int div_bits = 8;

  // APB bus widths
  localparam int apb_addr_bits = 5;
  localparam int apb_data_bits = 32;

  typedef logic [frame_bits-1:0]    frame_t;
  typedef logic [cs_sel_bits-1:0]   cs_sel_t;
  typedef logic [cs_count-1:0]      cs_n_t;
  typedef logic [div_bits-1:0]      div_t;
  typedef logic [apb_addr_bits-1:0] apb_addr_t;
  typedef logic [apb_data_bits-1:0] apb_data_t;

  // register map, byte offsets
  localparam apb_addr_t reg_txdata = 5'h00;
  // chip select in 1:0, divider in 15:8
  localparam apb_addr_t reg_ctrl   = 5'h04;
  // any write launches a frame
  localparam apb_addr_t reg_start  = 5'h08;
  // bit 0 busy, bit 1 sticky done
  localparam apb_addr_t reg_status = 5'h0C;
  localparam apb_addr_t reg_rxdata = 5'h10;

  // shift engine sequencing
  typedef enum logic [1:0] {
    idle,
    assert_cs,
    shift,
    release_cs
  } engine_state_t;

endpackage

/* spi_apb_port.sv */
// APB register file for one host: latches a transfer request and collects the received word
`timescale 1ns/100ps

module spi_apb_port
  import spi_pkg::*;
(
  input  logic      clk_in,
  input  logic      reset_n_in,
  // APB slave
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_addr_t paddr,
  input  apb_data_t pwdata,
  output apb_data_t prdata,
  output logic      pready,
  output logic      pslverr,
  // request towards the arbiter
  output logic      req,
  output frame_t    req_tx_data,
  output cs_sel_t   req_cs_sel,
  output div_t      req_div,
  // result from the arbiter
  input  logic      done,
  input  frame_t    rx_data
);

  frame_t  tx_data_r;
  frame_t  rx_data_r;
  cs_sel_t cs_sel_r;
  div_t    div_r;
  logic    busy_r;
  logic    done_r;

  logic access;
  logic mapped;
  logic locked_reg;
  logic wr_ok;

  assign access = psel && penable;

  // address decode
  always_comb begin
    mapped     = 1'b0;
    locked_reg = 1'b0;
    case (paddr)
      reg_txdata, reg_ctrl, reg_start: begin
        mapped     = 1'b1;
        locked_reg = 1'b1;
      end
      reg_status, reg_rxdata: begin
        mapped = 1'b1;
      end
      default: begin
        mapped = 1'b0;
      end
    endcase
  end

  // no wait states
  assign pready = 1'b1;

  // unmapped, or a config write while a frame is pending
  assign pslverr = access && (!mapped || (pwrite && busy_r && locked_reg));

  assign wr_ok = access && pwrite && !pslverr;

  always_comb begin
    case (paddr)
      reg_txdata: prdata = tx_data_r;
      reg_ctrl:   prdata = {16'h0000, div_r, 6'b000000, cs_sel_r};
      reg_status: prdata = {30'h0, done_r, busy_r};
      reg_rxdata: prdata = rx_data_r;
      default:    prdata = '0;
    endcase
  end

  // control state
  always_ff @(posedge clk_in) begin
    if (!reset_n_in) begin
      busy_r   <= 1'b0;
      done_r   <= 1'b0;
      cs_sel_r <= '0;
      div_r    <= '0;
    end else begin
      if (wr_ok && paddr == reg_ctrl) begin
        cs_sel_r <= pwdata[1:0];
        div_r    <= pwdata[15:8];
      end
      if (wr_ok && paddr == reg_start) begin
        busy_r <= 1'b1;
        done_r <= 1'b0;
      end else if (done) begin
        busy_r <= 1'b0;
        done_r <= 1'b1;
      end
    end
  end

  // data words
  always_ff @(posedge clk_in) begin
    if (wr_ok && paddr == reg_txdata) begin
      tx_data_r <= pwdata;
    end
    if (done) begin
      rx_data_r <= rx_data;
    end
  end

  // request held for the whole time the port is busy
  assign req         = busy_r;
  assign req_tx_data = tx_data_r;
  assign req_cs_sel  = cs_sel_r;
  assign req_div     = div_r;

endmodule

/* spi_arbiter.sv */
// Round-robin arbiter that hands the shared SPI engine to one of two host ports per frame
`timescale 1ns/100ps

module spi_arbiter
  import spi_pkg::*;
(
  input  logic    clk_in,
  input  logic    reset_n_in,
  // host port requests
  input  logic    req0,
  input  logic    req1,
  input  frame_t  tx_data0,
  input  frame_t  tx_data1,
  input  cs_sel_t cs_sel0,
  input  cs_sel_t cs_sel1,
  input  div_t    div0,
  input  div_t    div1,
  // results back to the ports
  output logic    done0,
  output logic    done1,
  output frame_t  rx_data0,
  output frame_t  rx_data1,
  // engine side
  output logic    eng_start,
  output frame_t  eng_tx_data,
  output cs_sel_t eng_cs_sel,
  output div_t    eng_div,
  input  logic    eng_busy,
  input  logic    eng_done,
  input  frame_t  eng_rx_data
);

  logic grant_held;
  logic grant_idx;
  logic last_served;
  logic pick;
  logic launch;

  // favour the port not served last when both wait
  assign pick   = (req0 && req1) ? ~last_served : req1;
  assign launch = (req0 || req1) && !grant_held && !eng_busy;

  always_ff @(posedge clk_in) begin
    if (!reset_n_in) begin
      grant_held  <= 1'b0;
      grant_idx   <= 1'b0;
      last_served <= 1'b1;
      eng_start   <= 1'b0;
    end else begin
      eng_start <= launch;
      if (launch) begin
        grant_held  <= 1'b1;
        grant_idx   <= pick;
        last_served <= pick;
      end else if (eng_done && grant_held) begin
        grant_held <= 1'b0;
      end
    end
  end

  // granted port drives the engine
  assign eng_tx_data = grant_idx ? tx_data1 : tx_data0;
  assign eng_cs_sel  = grant_idx ? cs_sel1 : cs_sel0;
  assign eng_div     = grant_idx ? div1 : div0;

  // completion goes only to the owner
  assign done0    = eng_done && grant_held && !grant_idx;
  assign done1    = eng_done && grant_held && grant_idx;
  assign rx_data0 = eng_rx_data;
  assign rx_data1 = eng_rx_data;

endmodule

/* spi_engine.sv */
// SPI mode 3 shift engine: runs one 32-bit frame on a selected chip select per start pulse
`timescale 1ns/100ps

module spi_engine
  import spi_pkg::*;
(
  input  logic    clk_in,
  input  logic    reset_n_in,
  // frame request
  input  logic    start,
  input  frame_t  tx_data,
  input  cs_sel_t cs_sel,
  input  div_t    div,
  // status and result
  output logic    busy,
  output logic    done,
  output frame_t  rx_data,
  // SPI pins
  output logic    sclk,
  output logic    mosi,
  output cs_n_t   cs_n,
  input  logic    miso
);

  localparam logic [bit_cnt_bits-1:0] last_bit = bit_cnt_bits'(frame_bits - 1);

  engine_state_t state;

  div_t                    div_q;
  cs_sel_t                 cs_sel_q;
  div_t                    half_cnt;
  logic [bit_cnt_bits-1:0] bit_cnt;
  frame_t                  tx_shift;
  frame_t                  rx_shift;
  logic                    sclk_q;
  logic                    mosi_q;
  logic                    done_q;

  logic half_end;
  logic fall_edge;
  logic rise_edge;

  // end of a serial clock half-period
  assign half_end = (state != idle) && (half_cnt == div_q);

  // first fall leaves assert_cs, later falls come from a high sclk in shift
  assign fall_edge = half_end &&
                     ((state == assert_cs) || (state == shift && sclk_q));
  assign rise_edge = half_end && (state == shift) && !sclk_q;

  always_ff @(posedge clk_in) begin
    if (!reset_n_in) begin
      state    <= idle;
      div_q    <= '0;
      cs_sel_q <= '0;
      half_cnt <= '0;
      bit_cnt  <= '0;
      sclk_q   <= 1'b1;
      mosi_q   <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      done_q <= 1'b0;

      // half-period timer, restarts on every edge
      if (state == idle || half_end) begin
        half_cnt <= '0;
      end else begin
        half_cnt <= half_cnt + 1'b1;
      end

      if (fall_edge) begin
        sclk_q <= 1'b0;
        mosi_q <= tx_shift[frame_bits-1];
      end
      if (rise_edge) begin
        sclk_q <= 1'b1;
      end

      case (state)
        idle: begin
          if (start) begin
            state    <= assert_cs;
            div_q    <= div;
            cs_sel_q <= cs_sel;
            bit_cnt  <= '0;
          end
        end
        assert_cs: begin
          if (half_end) begin
            state <= shift;
          end
        end
        shift: begin
          if (rise_edge) begin
            if (bit_cnt == last_bit) begin
              state <= release_cs;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        release_cs: begin
          // hold cs one more half-period after the last rise
          if (half_end) begin
            state  <= idle;
            mosi_q <= 1'b0;
            done_q <= 1'b1;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // data shifters, MSB first
  always_ff @(posedge clk_in) begin
    if (state == idle && start) begin
      tx_shift <= tx_data;
    end else if (fall_edge) begin
      tx_shift <= {tx_shift[frame_bits-2:0], 1'b0};
    end
    if (rise_edge) begin
      rx_shift <= {rx_shift[frame_bits-2:0], miso};
    end
  end

  assign busy    = (state != idle);
  assign done    = done_q;
  assign rx_data = rx_shift;
  assign sclk    = sclk_q;
  assign mosi    = mosi_q;

  // one active-low select while a frame is open
  assign cs_n = (state == idle) ? '1 : ~(cs_n_t'(1) << cs_sel_q);

endmodule

/* spi_subsystem_top.sv */
// Top level of the SPI master subsystem: two APB host ports sharing one arbitrated shift engine
`timescale 1ns/100ps

module spi_subsystem_top
  import spi_pkg::*;
(
  input  logic      clk_in,
  input  logic      reset_n_in,
  // host 0 APB
  input  logic      apb0_psel,
  input  logic      apb0_penable,
  input  logic      apb0_pwrite,
  input  apb_addr_t apb0_paddr,
  input  apb_data_t apb0_pwdata,
  output apb_data_t apb0_prdata,
  output logic      apb0_pready,
  output logic      apb0_pslverr,
  // host 1 APB
  input  logic      apb1_psel,
  input  logic      apb1_penable,
  input  logic      apb1_pwrite,
  input  apb_addr_t apb1_paddr,
  input  apb_data_t apb1_pwdata,
  output apb_data_t apb1_prdata,
  output logic      apb1_pready,
  output logic      apb1_pslverr,
  // SPI pins
  output logic      sclk,
  output logic      mosi,
  output cs_n_t     cs_n,
  input  logic      miso
);

  logic    req0, req1, done0, done1;
  frame_t  tx_data0, tx_data1, rx_data0, rx_data1;
  cs_sel_t cs_sel0, cs_sel1;
  div_t    div0, div1;

  logic    eng_start, eng_busy, eng_done;
  frame_t  eng_tx_data, eng_rx_data;
  cs_sel_t eng_cs_sel;
  div_t    eng_div;

  spi_apb_port u_port0 (
    .clk_in(clk_in), .reset_n_in(reset_n_in),
    .psel(apb0_psel), .penable(apb0_penable), .pwrite(apb0_pwrite),
    .paddr(apb0_paddr), .pwdata(apb0_pwdata), .prdata(apb0_prdata),
    .pready(apb0_pready), .pslverr(apb0_pslverr),
    .req(req0), .req_tx_data(tx_data0), .req_cs_sel(cs_sel0), .req_div(div0),
    .done(done0), .rx_data(rx_data0)
  );

  spi_apb_port u_port1 (
    .clk_in(clk_in), .reset_n_in(reset_n_in),
    .psel(apb1_psel), .penable(apb1_penable), .pwrite(apb1_pwrite),
    .paddr(apb1_paddr), .pwdata(apb1_pwdata), .prdata(apb1_prdata),
    .pready(apb1_pready), .pslverr(apb1_pslverr),
    .req(req1), .req_tx_data(tx_data1), .req_cs_sel(cs_sel1), .req_div(div1),
    .done(done1), .rx_data(rx_data1)
  );

  spi_arbiter u_arbiter (
    .clk_in(clk_in), .reset_n_in(reset_n_in),
    .req0(req0), .req1(req1), .tx_data0(tx_data0), .tx_data1(tx_data1),
    .cs_sel0(cs_sel0), .cs_sel1(cs_sel1), .div0(div0), .div1(div1),
    .done0(done0), .done1(done1), .rx_data0(rx_data0), .rx_data1(rx_data1),
    .eng_start(eng_start), .eng_tx_data(eng_tx_data), .eng_cs_sel(eng_cs_sel),
    .eng_div(eng_div), .eng_busy(eng_busy), .eng_done(eng_done),
    .eng_rx_data(eng_rx_data)
  );

  spi_engine u_engine (
    .clk_in(clk_in), .reset_n_in(reset_n_in),
    .start(eng_start), .tx_data(eng_tx_data), .cs_sel(eng_cs_sel), .div(eng_div),
    .busy(eng_busy), .done(eng_done), .rx_data(eng_rx_data),
    .sclk(sclk), .mosi(mosi), .cs_n(cs_n), .miso(miso)
  );

endmodule

/* spi_slave_model.sv */
// Testbench SPI mode 3 slave for one chip select; echoes the word it captured in its previous frame
`timescale 1ns/100ps

module spi_slave_model
  import spi_pkg::*;
(
  input  logic    reset_n_in,
  input  cs_sel_t index,
  input  logic    sclk,
  input  logic    cs_n,
  input  logic    mosi,
  output logic    miso,
  output frame_t  last_word
);

  frame_t out_shift;
  frame_t in_shift;

  // word of the last complete frame, seeded with the replicated index
  always @(posedge cs_n or negedge reset_n_in) begin
    if (!reset_n_in) begin
      last_word <= {(frame_bits / cs_sel_bits){index}};
    end else begin
      last_word <= in_shift;
    end
  end

  // frame opens, echo word loaded
  always @(negedge cs_n) begin
    out_shift <= last_word;
    in_shift  <= '0;
    miso      <= 1'b0;
  end

  // mode 3 drives on the falling edge
  always @(negedge sclk) begin
    if (!cs_n) begin
      miso      <= out_shift[frame_bits-1];
      out_shift <= {out_shift[frame_bits-2:0], 1'b0};
    end
  end

  // and samples on the rising edge
  always @(posedge sclk) begin
    if (!cs_n) begin
      in_shift <= {in_shift[frame_bits-2:0], mosi};
    end
  end

endmodule

/* spi_tb.sv */
// Simulation top that drives random APB traffic on both SPI hosts and checks it against an echo model
`timescale 1ns/100ps

module spi_tb
  import spi_pkg::*;
();

  localparam int unsigned seed_value = 32'h2487_a66c;
  // room for about 40 frames of 16384 cycles at the slowest divider plus APB traffic
  localparam int cycle_limit = 1_000_000;

  logic                           clk_in;
  logic                           reset_n_in;
  logic [1:0]                     psel;
  logic [1:0]                     penable;
  logic [1:0]                     pwrite;
  logic [1:0][apb_addr_bits-1:0]  paddr;
  logic [1:0][apb_data_bits-1:0]  pwdata;
  wire  [1:0][apb_data_bits-1:0]  prdata;
  wire  [1:0]                     pready;
  wire  [1:0]                     pslverr;
  logic                           sclk;
  logic                           mosi;
  logic                           miso;
  cs_n_t                          cs_n;
  wire  [cs_count-1:0]            slave_miso;
  wire  [cs_count-1:0][frame_bits-1:0] slave_word;

  // echo model keeps the last word sent to each chip select
  frame_t model_word [cs_count];
  cs_n_t  cs_seen;
  logic   cs_overlap;
  int     cycles;
  int     checks;
  int     errors;
  int     tests;
  int     test_start_errors;

  always #5 clk_in = ~clk_in;

  spi_subsystem_top u_dut (
    .clk_in(clk_in), .reset_n_in(reset_n_in),
    .apb0_psel(psel[0]), .apb0_penable(penable[0]), .apb0_pwrite(pwrite[0]),
    .apb0_paddr(paddr[0]), .apb0_pwdata(pwdata[0]), .apb0_prdata(prdata[0]),
    .apb0_pready(pready[0]), .apb0_pslverr(pslverr[0]),
    .apb1_psel(psel[1]), .apb1_penable(penable[1]), .apb1_pwrite(pwrite[1]),
    .apb1_paddr(paddr[1]), .apb1_pwdata(pwdata[1]), .apb1_prdata(prdata[1]),
    .apb1_pready(pready[1]), .apb1_pslverr(pslverr[1]),
    .sclk(sclk), .mosi(mosi), .cs_n(cs_n), .miso(miso)
  );

  for (genvar i = 0; i < cs_count; i++) begin : g_slave
    spi_slave_model u_slave (
      .reset_n_in(reset_n_in), .index(cs_sel_t'(i)), .sclk(sclk), .cs_n(cs_n[i]),
      .mosi(mosi), .miso(slave_miso[i]), .last_word(slave_word[i])
    );
  end

  // only the selected slave reaches the shared miso line
  assign miso = |(slave_miso & ~cs_n);

  // record which selects went low and whether two were low together
  always @(negedge clk_in) begin
    if (reset_n_in) begin
      cs_seen = cs_seen | ~cs_n;
      if ($countones(~cs_n) > 1) begin
        cs_overlap = 1'b1;
      end
    end
  end

  always @(posedge clk_in) begin
    cycles = cycles + 1;
    if (cycles == cycle_limit) begin
      $display("timeout: run did not finish within %0d clock cycles", cycle_limit);
      $display("Verification failed");
      $finish;
    end
  end

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // one APB transfer that starts and ends 1 ns after a rising edge
  task automatic apb_access(input int port, input logic write, input apb_addr_t addr,
                            input apb_data_t wdata, output apb_data_t rdata,
                            output logic err);
    psel[port]    = 1'b1;
    penable[port] = 1'b0;
    pwrite[port]  = write;
    paddr[port]   = addr;
    pwdata[port]  = wdata;
    @(posedge clk_in);
    #1;
    penable[port] = 1'b1;
    // responses settled by mid-cycle
    @(negedge clk_in);
    rdata = prdata[port];
    err   = pslverr[port];
    check_value($sformatf("port %0d pready in access phase", port), pready[port], 1'b1);
    @(posedge clk_in);
    #1;
    psel[port]    = 1'b0;
    penable[port] = 1'b0;
  endtask

  task automatic apb_write(input int port, input apb_addr_t addr, input apb_data_t data,
                           input logic exp_err);
    apb_data_t rdata;
    logic      err;
    apb_access(port, 1'b1, addr, data, rdata, err);
    check_value($sformatf("port %0d pslverr on write to %h", port, addr), err, exp_err);
  endtask

  task automatic apb_read(input int port, input apb_addr_t addr, output apb_data_t data,
                          input logic exp_err);
    logic err;
    apb_access(port, 1'b0, addr, '0, data, err);
    check_value($sformatf("port %0d pslverr on read of %h", port, addr), err, exp_err);
  endtask

  function automatic apb_data_t ctrl_word(input cs_sel_t cs, input div_t div);
    return {16'h0000, div, 6'b000000, cs};
  endfunction

  task automatic start_transfer(input int port, input frame_t word, input cs_sel_t cs,
                                input div_t div);
    apb_write(port, reg_txdata, word, 1'b0);
    apb_write(port, reg_ctrl, ctrl_word(cs, div), 1'b0);
    apb_write(port, reg_start, 32'h1, 1'b0);
  endtask

  // poll status until the sticky done bit shows
  task automatic finish_transfer(input int port, input cs_sel_t cs, input frame_t word);
    apb_data_t status;
    apb_data_t rx;
    logic      err;
    status = '0;
    while (!status[1]) begin
      apb_access(port, 1'b0, reg_status, '0, status, err);
    end
    apb_read(port, reg_rxdata, rx, 1'b0);
    check_value($sformatf("port %0d rxdata from cs %0d", port, cs), rx, model_word[cs]);
    check_value($sformatf("word captured by slave %0d", cs), slave_word[cs], word);
    model_word[cs] = word;
  endtask

  task automatic end_test(input string name);
    tests++;
    check_value("more than one cs_n low at once", cs_overlap, 1'b0);
    if (errors == test_start_errors) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      $display("test %0d %s: %0d errors", tests, name, errors - test_start_errors);
    end
    test_start_errors = errors;
    cs_seen           = '0;
    cs_overlap        = 1'b0;
  endtask

  initial begin
    int unsigned seed;
    apb_data_t   rd;
    frame_t      word;
    frame_t      word1;
    cs_sel_t     cs;
    cs_sel_t     cs1;
    div_t        div;
    div_t        div1;
    int          port;
    clk_in            = 1'b0;
    reset_n_in        = 1'b0;
    psel              = '0;
    penable           = '0;
    pwrite            = '0;
    paddr             = '0;
    pwdata            = '0;
    cycles            = 0;
    checks            = 0;
    errors            = 0;
    tests             = 0;
    test_start_errors = 0;
    cs_seen           = '0;
    cs_overlap        = 1'b0;
    // seed the generator once
    seed = seed_value;
    word = $urandom(seed);
    for (int i = 0; i < cs_count; i++) begin
      model_word[i] = {(frame_bits / cs_sel_bits){cs_sel_t'(i)}};
    end
    repeat (8) @(posedge clk_in);
    #1;
    reset_n_in = 1'b1;

    apb_read(0, reg_status, rd, 1'b0);
    check_value("port 0 status after reset", rd, 32'h0);
    apb_read(1, reg_status, rd, 1'b0);
    check_value("port 1 status after reset", rd, 32'h0);
    check_value("cs_n after reset", cs_n, 4'hf);
    check_value("sclk after reset", sclk, 1'b1);
    check_value("mosi after reset", mosi, 1'b0);
    end_test("reset state");

    word = $urandom;
    cs   = $urandom_range(3, 0);
    div  = $urandom_range(3, 0);
    start_transfer(0, word, cs, div);
    finish_transfer(0, cs, word);
    check_value("cs_n lines used by the frame", cs_seen, cs_n_t'(1 << cs));
    end_test("single transfer");

    // second port picks a different chip select
    word  = $urandom;
    word1 = $urandom;
    cs    = $urandom_range(3, 0);
    cs1   = cs + cs_sel_t'($urandom_range(3, 1));
    div   = $urandom_range(3, 0);
    div1  = $urandom_range(3, 0);
    fork
      start_transfer(0, word, cs, div);
      start_transfer(1, word1, cs1, div1);
    join
    finish_transfer(0, cs, word);
    finish_transfer(1, cs1, word1);
    end_test("simultaneous requests");

    word = $urandom;
    cs   = $urandom_range(3, 0);
    div  = 8'd15;
    start_transfer(1, word, cs, div);
    apb_read(1, reg_status, rd, 1'b0);
    check_value("port 1 status while busy", rd, 32'h1);
    apb_write(1, reg_txdata, ~word, 1'b1);
    apb_write(1, reg_ctrl, ctrl_word(cs_sel_t'(cs + 1), 8'd3), 1'b1);
    apb_write(1, reg_start, 32'h1, 1'b1);
    finish_transfer(1, cs, word);
    apb_read(1, reg_txdata, rd, 1'b0);
    check_value("port 1 txdata after rejected write", rd, word);
    apb_read(1, reg_ctrl, rd, 1'b0);
    check_value("port 1 ctrl after rejected write", rd, ctrl_word(cs, div));
    apb_read(1, reg_status, rd, 1'b0);
    check_value("port 1 status after rejected start", rd, 32'h2);
    end_test("busy writes rejected");

    apb_write(0, 5'h14, $urandom, 1'b1);
    apb_read(0, 5'h1c, rd, 1'b1);
    apb_read(1, 5'h02, rd, 1'b1);
    word = $urandom;
    apb_write(0, reg_txdata, word, 1'b0);
    apb_read(0, reg_txdata, rd, 1'b0);
    check_value("port 0 txdata readback", rd, word);
    word = $urandom;
    apb_write(1, reg_ctrl, word, 1'b0);
    apb_read(1, reg_ctrl, rd, 1'b0);
    // only the chip select and divider fields are kept
    check_value("port 1 ctrl readback", rd, word & 32'h0000_ff03);
    end_test("register map");

    repeat (30) begin
      port = $urandom_range(1, 0);
      word = $urandom;
      cs   = $urandom_range(3, 0);
      div  = $urandom_range(7, 0);
      start_transfer(port, word, cs, div);
      finish_transfer(port, cs, word);
    end
    end_test("random transfers");

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* filelist.f */
spi_pkg.sv
spi_apb_port.sv
spi_arbiter.sv
spi_engine.sv
spi_subsystem_top.sv
spi_slave_model.sv
spi_tb.sv
